//--- src.f
+incdir+verilog
verilog/median_pkg.sv
verilog/win_if.sv
verilog/sort3_net.sv
verilog/sort5_pipe.sv
verilog/median_5x5_calc.sv
verilog/line_buffer.sv
verilog/window_builder.sv
verilog/frame_counter.sv
verilog/stream_ctrl.sv
verilog/median_filter_top.sv
tb/median_filter_properties.sv
tb/median_filter_tb.sv

//--- tb/median_filter_tb.sv
`default_nettype none

`include "median_settings.svh"

module median_filter_tb;
  import median_pkg::*;

  localparam int N_PIX   = `IMG_W * `IMG_H;
  localparam int N_OUT   = (`IMG_W - 4) * (`IMG_H - 4);
  localparam int TIMEOUT = 3 * N_PIX * 4 + `MED_LAT + 200;

  logic   clk;
  logic   rst_n;
  logic   in_valid_i;
  logic   in_ready_o;
  logic   in_sof_i;
  pixel_t in_pixel_i;
  logic   out_valid_o;
  logic   out_ready_i;
  pixel_t out_pixel_o;
  logic   out_last_o;

  integer seed;
  logic   stalls;
  int     cycles;
  int     out_cnt;
  int     frames_done;
  pixel_t exp_pix;
  pixel_t exp_q[$];
  pixel_t frames [3][`IMG_H][`IMG_W];

  median_filter_top u_median_filter_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_sof_i    (in_sof_i),
    .in_pixel_i  (in_pixel_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_pixel_o (out_pixel_o),
    .out_last_o  (out_last_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // 13th smallest of the 25 pixels ending at (r, c)
  function automatic pixel_t window_median(input int f, input int r, input int c);
    pixel_t vals [25];
    pixel_t t;
    int     n;
    n = 0;
    for (int dr = -4; dr <= 0; dr++) begin
      for (int dc = -4; dc <= 0; dc++) begin
        vals[n] = frames[f][r+dr][c+dc];
        n++;
      end
    end
    for (int i = 0; i < 24; i++) begin
      for (int j = 0; j < 24 - i; j++) begin
        if (vals[j] > vals[j+1]) begin
          t = vals[j];
          vals[j] = vals[j+1];
          vals[j+1] = t;
        end
      end
    end
    return vals[12];
  endfunction

  task automatic build_frames();
    for (int f = 0; f < 3; f++) begin
      for (int r = 0; r < `IMG_H; r++) begin
        for (int c = 0; c < `IMG_W; c++) begin
          // last frame uses a narrow range so ties are common
          if (f == 2)
            frames[f][r][c] = pixel_t'($random(seed) & 7);
          else
            frames[f][r][c] = pixel_t'($random(seed));
        end
      end
      for (int r = 4; r < `IMG_H; r++) begin
        for (int c = 4; c < `IMG_W; c++) begin
          exp_q.push_back(window_median(f, r, c));
        end
      end
    end
  endtask

  task automatic send_frame(input int f, input logic gaps);
    int idx;
    idx = 0;
    while (idx < N_PIX) begin
      if (gaps && (($random(seed) & 3) == 0)) begin
        in_valid_i <= 1'b0;
        in_sof_i   <= 1'b0;
        @(posedge clk);
      end else begin
        in_valid_i <= 1'b1;
        in_sof_i   <= (idx == 0);
        in_pixel_i <= frames[f][idx / `IMG_W][idx % `IMG_W];
        @(posedge clk);
        while (!in_ready_o) @(posedge clk);
        idx++;
      end
    end
    in_valid_i <= 1'b0;
    in_sof_i   <= 1'b0;
  endtask

  always @(posedge clk) begin
    out_ready_i <= stalls ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // output checks on every delivered pixel
  always @(posedge clk) begin
    if (rst_n && out_valid_o && out_ready_i) begin
      assert (exp_q.size() != 0)
      else abort_run("output delivered with no window pending");
      exp_pix = exp_q.pop_front();
      assert (out_pixel_o == exp_pix)
      else abort_run($sformatf("Fail at time %0t: median %0d, expected %0d",
                               $time, out_pixel_o, exp_pix));
      assert (out_last_o == (out_cnt == N_OUT - 1))
      else abort_run($sformatf("Fail at time %0t: last flag %0b on output %0d of frame",
                               $time, out_last_o, out_cnt));
      if (out_cnt == N_OUT - 1) begin
        out_cnt = 0;
        frames_done++;
      end else begin
        out_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (u_median_filter_top.u_median_filter_properties.err_cnt != 0)
      abort_run("a bound assertion on the DUT failed");
    else if (cycles >= TIMEOUT)
      abort_run($sformatf("timeout after %0d cycles, frames not complete", cycles));
  end

  initial begin
    seed        = 165;
    rst_n       = 1'b0;
    in_valid_i  = 1'b0;
    in_sof_i    = 1'b0;
    in_pixel_i  = '0;
    out_ready_i = 1'b1;
    stalls      = 1'b0;
    cycles      = 0;
    out_cnt     = 0;
    frames_done = 0;
    build_frames();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // first frame clean, later ones with gaps and stalls
    send_frame(0, 1'b0);
    stalls <= 1'b1;
    send_frame(1, 1'b1);
    send_frame(2, 1'b1);
    wait (frames_done == 3);
    // watch for stray outputs
    repeat (`MED_LAT + 4) @(posedge clk);
    if (exp_q.size() == 0 && out_cnt == 0 &&
        u_median_filter_top.u_median_filter_properties.err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("output count does not match the expected medians");
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/median_filter_properties.sv
`default_nettype none

`include "median_settings.svh"

module median_filter_properties (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      in_ready_i,
  input logic                      in_sof_i,
  input logic                      out_valid_i,
  input logic                      out_ready_i,
  input median_pkg::pixel_t        out_pixel_i,
  input logic                      out_last_i,
  input logic                      in_step_i,
  input logic [$clog2(`IMG_W)-1:0] col_i,
  input logic [$clog2(`IMG_H)-1:0] row_i,
  input logic                      adv_i,
  input median_pkg::ctrl_state_t   state_i
);
  import median_pkg::*;

  int   err_cnt = 0;
  logic win_valid;
  logic draining;

  // interior pixel accepted this cycle
  assign win_valid = in_step_i && (col_i >= 'd4) && (row_i >= 'd4);

  // frame drains from its final accepted pixel to its last output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      draining <= 1'b0;
    end else if (in_step_i && (col_i == `IMG_W - 1) && (row_i == `IMG_H - 1)) begin
      draining <= 1'b1;
    end else if (out_valid_i && out_ready_i && out_last_i) begin
      draining <= 1'b0;
    end
  end

  // stalled output holds until delivery
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_pixel_i) && $stable(out_last_i))
  else begin
    err_cnt++;
    $error("output changed while stalled");
  end

  a_reset: assert property (@(posedge clk)
    !rst_n |=> !in_ready_i && !out_valid_i && !out_last_i)
  else begin
    err_cnt++;
    $error("handshake outputs not low after reset");
  end

  // no input while the frame drains
  a_drain_block: assert property (@(posedge clk) disable iff (!rst_n)
    draining |-> state_i == DRAIN && !in_ready_i)
  else begin
    err_cnt++;
    $error("input accepted during drain");
  end

  // next frame is taken right after the last output leaves
  a_sof_ready: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid_i && out_ready_i && out_last_i) ##1 (in_sof_i && adv_i) |-> in_ready_i)
  else begin
    err_cnt++;
    $error("start of frame pixel not accepted after the frame drained");
  end

  // window tag reaches the output after MED_LAT advancing cycles
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    win_valid ##1 adv_i [*(`MED_LAT - 1)] |=> out_valid_i)
  else begin
    err_cnt++;
    $error("median latency differs from pipeline depth");
  end

endmodule

bind median_filter_top median_filter_properties u_median_filter_properties (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_ready_i  (in_ready_o),
  .in_sof_i    (in_sof_i),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_pixel_i (out_pixel_o),
  .out_last_i  (out_last_o),
  .in_step_i   (in_step),
  .col_i       (col),
  .row_i       (row),
  .adv_i       (adv),
  .state_i     (state)
);

`default_nettype wire

//--- verilog/median_filter_top.sv
`default_nettype none

`include "median_settings.svh"

module median_filter_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  logic               in_sof_i,
  input  median_pkg::pixel_t in_pixel_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output median_pkg::pixel_t out_pixel_o,
  output logic               out_last_o
);
  import median_pkg::*;

  logic                      adv;
  logic                      in_step;
  logic                      out_step;
  logic [$clog2(`IMG_W)-1:0] col;
  logic [$clog2(`IMG_H)-1:0] row;
  logic                      in_last;
  logic                      cnt_out_last;
  ctrl_state_t               state;

  win_if u_win_if ();

  assign in_step      = in_valid_i & in_ready_o;
  assign out_step     = out_valid_o & out_ready_i;
  assign out_last_o   = out_valid_o & cnt_out_last;
  assign u_win_if.adv = adv;

  stream_ctrl u_stream_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (in_valid_i),
    .in_sof_i    (in_sof_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .in_last_i   (in_last),
    .out_last_i  (out_last_o),
    .in_ready_o  (in_ready_o),
    .adv_o       (adv),
    .state_o     (state)
  );

  frame_counter u_frame_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_step_i  (in_step),
    .out_step_i (out_step),
    .col_o      (col),
    .row_o      (row),
    .in_last_o  (in_last),
    .out_last_o (cnt_out_last)
  );

  window_builder u_window_builder (
    .clk     (clk),
    .rst_n   (rst_n),
    .shift_i (in_step),
    .pixel_i (in_pixel_i),
    .col_i   (col),
    .row_i   (row),
    .win     (u_win_if.src)
  );

  median_5x5_calc u_median_5x5_calc (
    .clk      (clk),
    .rst_n    (rst_n),
    .win      (u_win_if.snk),
    .median_o (out_pixel_o),
    .valid_o  (out_valid_o)
  );

endmodule

`default_nettype wire

//--- verilog/stream_ctrl.sv
`default_nettype none

module stream_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    in_valid_i,
  input  logic                    in_sof_i,
  input  logic                    out_valid_i,
  input  logic                    out_ready_i,
  input  logic                    in_last_i,
  input  logic                    out_last_i,
  output logic                    in_ready_o,
  output logic                    adv_o,
  output median_pkg::ctrl_state_t state_o
);
  import median_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        accept;

  // pipeline moves unless the output is stalled
  assign adv_o      = ~out_valid_i | out_ready_i;
  assign in_ready_o = adv_o & ((state_q == RUN) | ((state_q == IDLE) & in_sof_i));
  assign accept     = in_valid_i & in_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = RUN;
      RUN:     if (accept && in_last_i) state_d = DRAIN;
      // wait for the last median to leave
      DRAIN:   if (out_valid_i && out_ready_i && out_last_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

`default_nettype wire

//--- verilog/frame_counter.sv
`default_nettype none

`include "median_settings.svh"

module frame_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_step_i,
  input  logic                      out_step_i,
  output logic [$clog2(`IMG_W)-1:0] col_o,
  output logic [$clog2(`IMG_H)-1:0] row_o,
  output logic                      in_last_o,
  output logic                      out_last_o
);

  localparam int OUT_N = (`IMG_W - 4) * (`IMG_H - 4);

  logic [$clog2(OUT_N)-1:0] out_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_o   <= '0;
      row_o   <= '0;
      out_cnt <= '0;
    end else begin
      if (in_step_i) begin
        if (col_o == `IMG_W - 1) begin
          col_o <= '0;
          row_o <= (row_o == `IMG_H - 1) ? '0 : row_o + 1'b1;
        end else begin
          col_o <= col_o + 1'b1;
        end
      end
      if (out_step_i) begin
        out_cnt <= out_last_o ? '0 : out_cnt + 1'b1;
      end
    end
  end

  assign in_last_o  = (col_o == `IMG_W - 1) && (row_o == `IMG_H - 1);
  // next delivered pixel closes the frame
  assign out_last_o = (out_cnt == OUT_N - 1);

endmodule

`default_nettype wire

//--- verilog/window_builder.sv
`default_nettype none

`include "median_settings.svh"

module window_builder (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      shift_i,
  input  median_pkg::pixel_t        pixel_i,
  input  logic [$clog2(`IMG_W)-1:0] col_i,
  input  logic [$clog2(`IMG_H)-1:0] row_i,
  win_if.src                        win
);
  import median_pkg::*;

  pixel_t [3:0] taps;
  window_t      win_q;
  window_t      win_d;

  line_buffer u_line_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .shift_i (shift_i),
    .col_i   (col_i),
    .pixel_i (pixel_i),
    .taps_o  (taps)
  );

  // drop the oldest column, append taps plus new pixel
  always_comb begin
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 4; c++) begin
        win_d[r][c] = win_q[r][c+1];
      end
    end
    for (int r = 0; r < 4; r++) begin
      win_d[r][4] = taps[3-r];
    end
    win_d[4][4] = pixel_i;
  end

  always_ff @(posedge clk) begin
    if (shift_i) begin
      win_q <= win_d;
    end
  end

  // window seen by the pipeline on the accepting cycle
  assign win.win   = win_d;
  assign win.valid = shift_i && (col_i >= 'd4) && (row_i >= 'd4);

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
`default_nettype none

`include "median_settings.svh"

module line_buffer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      shift_i,
  input  logic [$clog2(`IMG_W)-1:0] col_i,
  input  median_pkg::pixel_t        pixel_i,
  output median_pkg::pixel_t [3:0]  taps_o
);
  import median_pkg::*;

  // one row per memory, row 0 is the newest stored row
  pixel_t mem0 [`IMG_W];
  pixel_t mem1 [`IMG_W];
  pixel_t mem2 [`IMG_W];
  pixel_t mem3 [`IMG_W];

  // rows older by 1 to 4 at the current column
  assign taps_o[0] = mem0[col_i];
  assign taps_o[1] = mem1[col_i];
  assign taps_o[2] = mem2[col_i];
  assign taps_o[3] = mem3[col_i];

  // no writes while in reset
  always_ff @(posedge clk) begin
    if (rst_n && shift_i) begin
      mem0[col_i] <= pixel_i;
      mem1[col_i] <= mem0[col_i];
      mem2[col_i] <= mem1[col_i];
      mem3[col_i] <= mem2[col_i];
    end
  end

endmodule

`default_nettype wire

//--- verilog/median_5x5_calc.sv
`default_nettype none

`include "median_settings.svh"

module median_5x5_calc (
  input  logic               clk,
  input  logic               rst_n,
  win_if.snk                 win,
  output median_pkg::pixel_t median_o,
  output logic               valid_o
);
  import median_pkg::*;

  localparam int VLD_LAT = `MED_LAT;

  window_t           win_q;
  pixel_t [4:0][4:0] row_s;      // [row][rank]
  pixel_t [4:0][4:0] col_in_q;   // [rank][row]
  pixel_t [4:0][4:0] col_s;      // [rank][sorted row]
  pixel_t [3:0]      d3_q;
  pixel_t [4:0]      d4_q;
  pixel_t [3:0]      d5_q;
  pixel_t [4:0]      d4_s;
  pixel_t            d3a_med;
  pixel_t            d3a_max;
  pixel_t            d3a_med_q;
  pixel_t            d3a_max_q;
  pixel_t            d3a_last_q;
  pixel_t            d3b_max;
  pixel_t            d3b_q;
  pixel_t            d3c_q;
  pixel_t            d5a_min;
  pixel_t            d5a_med;
  pixel_t            d5a_max;
  pixel_t            d5a_min_q;
  pixel_t            d5a_med_q;
  pixel_t            d5a_max_q;
  pixel_t            d5a_last_q;
  pixel_t            d5b_min;
  pixel_t            d5b_med;
  pixel_t            d5b_min_q;
  pixel_t            d5b_med_q;
  pixel_t            d5b_prev_q;
  pixel_t            d5c_min;
  pixel_t            d5c_q;
  pixel_t [2:0]      cand_q;
  pixel_t            final_med;
  pixel_t            median_q;
  logic [VLD_LAT-1:0] vld_q;

  always_ff @(posedge clk) begin
    if (win.adv) begin
      win_q <= win.win;
      // transpose row ranks into columns
      for (int r = 0; r < 5; r++) begin
        for (int k = 0; k < 5; k++) begin
          col_in_q[k][r] <= row_s[r][k];
        end
      end
      // candidate diagonals of the sorted matrix, C[j][k] = col_s[k][j]
      for (int i = 0; i < 5; i++) begin
        d4_q[i] <= col_s[4-i][i];
      end
      for (int i = 0; i < 4; i++) begin
        d3_q[i] <= col_s[3-i][i];
        d5_q[i] <= col_s[4-i][i+1];
      end
      d3a_med_q  <= d3a_med;
      d3a_max_q  <= d3a_max;
      d3a_last_q <= d3_q[3];
      d3b_q      <= d3b_max;
      d3c_q      <= d3b_q;
      d5a_min_q  <= d5a_min;
      d5a_med_q  <= d5a_med;
      d5a_max_q  <= d5a_max;
      d5a_last_q <= d5_q[3];
      d5b_min_q  <= d5b_min;
      d5b_med_q  <= d5b_med;
      d5b_prev_q <= d5a_min_q;
      d5c_q      <= d5c_min;
      cand_q     <= {d5c_q, d4_s[2], d3c_q};
      median_q   <= final_med;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (win.adv) begin
      vld_q <= {vld_q[VLD_LAT-2:0], win.valid};
    end
  end

  for (genvar g = 0; g < 5; g++) begin : g_sort
    sort5_pipe u_row (
      .clk   (clk),
      .rst_n (rst_n),
      .en_i  (win.adv),
      .s_i   (win_q[g]),
      .o_o   (row_s[g])
    );
    sort5_pipe u_col (
      .clk   (clk),
      .rst_n (rst_n),
      .en_i  (win.adv),
      .s_i   (col_in_q[g]),
      .o_o   (col_s[g])
    );
  end

  // anti-diagonal median
  sort5_pipe u_diag (
    .clk   (clk),
    .rst_n (rst_n),
    .en_i  (win.adv),
    .s_i   (d4_q),
    .o_o   (d4_s)
  );

  // max of the lower partial diagonal
  sort3_net u_d3_a (
    .a_i   (d3_q[0]),
    .b_i   (d3_q[1]),
    .c_i   (d3_q[2]),
    .min_o (),
    .med_o (d3a_med),
    .max_o (d3a_max)
  );
  sort3_net u_d3_b (
    .a_i   (d3a_max_q),
    .b_i   (d3a_med_q),
    .c_i   (d3a_last_q),
    .min_o (),
    .med_o (),
    .max_o (d3b_max)
  );

  // min of the upper partial diagonal
  sort3_net u_d5_a (
    .a_i   (d5_q[0]),
    .b_i   (d5_q[1]),
    .c_i   (d5_q[2]),
    .min_o (d5a_min),
    .med_o (d5a_med),
    .max_o (d5a_max)
  );
  sort3_net u_d5_b (
    .a_i   (d5a_last_q),
    .b_i   (d5a_med_q),
    .c_i   (d5a_max_q),
    .min_o (d5b_min),
    .med_o (d5b_med),
    .max_o ()
  );
  sort3_net u_d5_c (
    .a_i   (d5b_prev_q),
    .b_i   (d5b_min_q),
    .c_i   (d5b_med_q),
    .min_o (d5c_min),
    .med_o (),
    .max_o ()
  );

  sort3_net u_final (
    .a_i   (cand_q[0]),
    .b_i   (cand_q[1]),
    .c_i   (cand_q[2]),
    .min_o (),
    .med_o (final_med),
    .max_o ()
  );

  assign median_o = median_q;
  assign valid_o  = vld_q[VLD_LAT-1];

endmodule

`default_nettype wire

//--- verilog/sort5_pipe.sv
`default_nettype none

module sort5_pipe (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     en_i,
  input  median_pkg::pixel_t [4:0] s_i,
  output median_pkg::pixel_t [4:0] o_o
);
  import median_pkg::*;

  typedef pixel_t [4:0] vec5_t;

  vec5_t st1_d;
  vec5_t st1_q;
  vec5_t st2_d;
  vec5_t st2_q;
  vec5_t st3_d;
  vec5_t st3_q;

  // compare-exchange, smaller value ends up at lo
  function automatic vec5_t cex(input vec5_t v, input int lo, input int hi);
    vec5_t r;
    r = v;
    if (v[lo] > v[hi]) begin
      r[lo] = v[hi];
      r[hi] = v[lo];
    end
    return r;
  endfunction

  // sort pair 0/1 and triple 2..4
  assign st1_d = cex(cex(cex(s_i, 0, 1), 3, 4), 2, 4);
  // merge the pair into the triple
  assign st2_d = cex(cex(cex(st1_q, 2, 3), 1, 4), 0, 3);
  assign st3_d = cex(cex(cex(st2_q, 0, 2), 1, 3), 1, 2);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      st1_q <= '0;
      st2_q <= '0;
      st3_q <= '0;
    end else if (en_i) begin
      st1_q <= st1_d;
      st2_q <= st2_d;
      st3_q <= st3_d;
    end
  end

  assign o_o = st3_q;

endmodule

`default_nettype wire

//--- verilog/sort3_net.sv
`default_nettype none

module sort3_net (
  input  median_pkg::pixel_t a_i,
  input  median_pkg::pixel_t b_i,
  input  median_pkg::pixel_t c_i,
  output median_pkg::pixel_t min_o,
  output median_pkg::pixel_t med_o,
  output median_pkg::pixel_t max_o
);
  import median_pkg::*;

  pixel_t lo_ab;
  pixel_t hi_ab;
  pixel_t mid_bc;

  // order a and b
  assign lo_ab = (a_i < b_i) ? a_i : b_i;
  assign hi_ab = (a_i < b_i) ? b_i : a_i;

  // push the larger one against c
  assign mid_bc = (hi_ab < c_i) ? hi_ab : c_i;
  assign max_o  = (hi_ab < c_i) ? c_i : hi_ab;

  // settle min and med
  assign min_o = (lo_ab < mid_bc) ? lo_ab : mid_bc;
  assign med_o = (lo_ab < mid_bc) ? mid_bc : lo_ab;

endmodule

`default_nettype wire

//--- verilog/win_if.sv
`default_nettype none

interface win_if;
  import median_pkg::*;

  // full neighbourhood from the window builder
  window_t win;
  // interior window, shifted in this cycle
  logic    valid;
  // pipeline advance
  logic    adv;

  modport src (
    output win,
    output valid,
    input  adv
  );

  modport snk (
    input win,
    input valid,
    input adv
  );

endinterface

`default_nettype wire

//--- verilog/median_pkg.sv
`default_nettype none

`include "median_settings.svh"

package median_pkg;

  // one grayscale sample
  typedef logic [`PIX_W-1:0] pixel_t;

  // 5x5 neighbourhood, indexed [row][col]
  // row 0 is the oldest row, col 0 the oldest column
  typedef pixel_t [4:0][4:0] window_t;

  // frame controller
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/median_settings.svh
`ifndef MEDIAN_SETTINGS_SVH
`define MEDIAN_SETTINGS_SVH

// grayscale sample width
`define PIX_W 8

// frame size in pixels
`define IMG_W 16
`define IMG_H 10

// register stages inside one five-input sorter
`define SORT5_LAT 3
// advancing cycles from window tag to output valid
`define MED_LAT 14

`endif
